//--- save_state.f
hdl/save_state_pkg.sv
hdl/load_word_fifo.sv
hdl/bridge_save_reader.sv
hdl/save_state_fsm.sv
hdl/save_state_controller.sv
sim/tb_save_state.sv

//--- sim/tb_save_state.sv
`timescale 1ns/1ps

module tb_save_state;
  import save_state_pkg::*;

  localparam int SAVE_WORDS  = 16;
  localparam int LOAD_WRITES = 32;
  localparam int WAIT_LIMIT  = 200;
  // 40 cycles of 20 ns per word, plus margin
  localparam int WATCHDOG_NS = (SAVE_WORDS + LOAD_WRITES) * 40 * 20 + 4000;

  logic        clk_74a;
  logic        rst;
  logic        bridge_wr;
  logic        bridge_rd;
  logic [31:0] bridge_addr;
  logic [31:0] bridge_wr_data;
  logic [31:0] save_state_bridge_read_data;
  logic        savestate_load;
  logic        savestate_start;
  logic        savestate_load_ack;
  logic        savestate_load_busy;
  logic        savestate_load_ok;
  logic        savestate_start_ack;
  logic        savestate_start_busy;
  logic        savestate_start_ok;
  logic        ss_save;
  logic        ss_load;
  logic [63:0] ss_din;
  logic [63:0] ss_dout;
  logic        ss_req;
  logic        ss_busy;
  logic        ss_ack;

  integer      seed;
  int          ack_count = 0;
  int          save_pulses = 0;
  int          load_pulses = 0;
  // next bridge word address for save reads
  int          rd_index = 0;
  logic [31:0] last_read;
  // load stimulus, drawn before the host and manager run in parallel
  logic [31:0] load_data [LOAD_WRITES];
  logic [31:0] foreign_data [LOAD_WRITES];
  logic        foreign [LOAD_WRITES];
  int          load_gap [LOAD_WRITES];
  ss_state_e   fsm_state;

  save_state_controller dut (.*);

  // only for timeout messages
  assign fsm_state = dut.u_fsm.state;

  initial clk_74a = 1'b0;
  always #10 clk_74a = ~clk_74a;

  // strobes counted at the rising edge after they were driven
  always @(posedge clk_74a) begin
    if (!rst) begin
      if (ss_ack) begin
        ack_count <= ack_count + 1;
      end
      if (ss_save) begin
        save_pulses <= save_pulses + 1;
      end
      if (ss_load) begin
        load_pulses <= load_pulses + 1;
      end
    end
  end

  task automatic abort_run(input string reason);
    $display("%s", reason);
    $display("SIMULATION FAILED");
    $fatal(1, "stopped at first error");
  endtask

  task automatic check_value(input string name, input logic [63:0] actual,
                             input logic [63:0] expected);
    if (actual !== expected) begin
      abort_run($sformatf("MISMATCH %s: actual 0x%0h, expected 0x%0h",
                          name, actual, expected));
    end
  endtask

  // bridge is big endian, manager little endian
  function automatic logic [31:0] byte_swap(input logic [31:0] w);
    logic [31:0] r;
    for (int b = 0; b < 4; b++) begin
      r[8*b +: 8] = w[8*(3-b) +: 8];
    end
    return r;
  endfunction

  // one-cycle write strobe
  task automatic bridge_write(input logic [31:0] addr, input logic [31:0] data);
    @(negedge clk_74a);
    bridge_wr      = 1'b1;
    bridge_addr    = addr;
    bridge_wr_data = data;
    @(negedge clk_74a);
    bridge_wr = 1'b0;
  endtask

  // read strobe for one cycle, data taken a cycle later
  task automatic bridge_read(input logic [31:0] addr, output logic [31:0] data);
    @(negedge clk_74a);
    bridge_rd   = 1'b1;
    bridge_addr = addr;
    @(negedge clk_74a);
    bridge_rd = 1'b0;
    data      = save_state_bridge_read_data;
  endtask

  task automatic read_next_half(input logic [31:0] expected);
    logic [31:0] data;
    bridge_read(32'h4000_0000 + rd_index * 4, data);
    rd_index++;
    check_value("save_state_bridge_read_data", data, expected);
    last_read = data;
  endtask

  // returns on the falling edge where ss_ack is high
  task automatic wait_for_ack();
    int cycles;
    cycles = 0;
    while (ss_ack !== 1'b1) begin
      @(negedge clk_74a);
      cycles++;
      if (cycles > WAIT_LIMIT) begin
        abort_run($sformatf("no ss_ack from the DUT, fsm stuck in %s", fsm_state.name()));
      end
    end
  endtask

  task automatic save_session();
    logic [63:0] word;
    logic [31:0] data;
    @(negedge clk_74a);
    savestate_start = 1'b1;
    @(negedge clk_74a);
    check_value("ss_save", ss_save, 1);
    check_value("savestate_start_ack", savestate_start_ack, 1);
    check_value("savestate_start_ok", savestate_start_ok, 0);
    savestate_start = 1'b0;
    @(negedge clk_74a);
    check_value("ss_save", ss_save, 0);
    check_value("savestate_start_busy", savestate_start_busy, 1);
    ss_busy = 1'b1;
    for (int i = 0; i < SAVE_WORDS; i++) begin
      word[63:32] = $random(seed);
      word[31:0]  = $random(seed);
      // manager offers one word for a single cycle
      ss_din = word;
      ss_req = 1'b1;
      @(negedge clk_74a);
      ss_req = 1'b0;
      check_value("savestate_start_ok", savestate_start_ok, 1);
      read_next_half(byte_swap(word[31:0]));
      // same word address again
      bridge_read(32'h4000_0000 + (rd_index - 1) * 4, data);
      check_value("save_state_bridge_read_data", data, last_read);
      // new word address but outside the window
      bridge_read(32'h5000_0000 + rd_index * 4, data);
      check_value("save_state_bridge_read_data", data, last_read);
      // manager still waiting on the high half
      check_value("ss_ack count", ack_count, i);
      check_value("ss_ack", ss_ack, 0);
      read_next_half(byte_swap(word[63:32]));
      wait_for_ack();
    end
    // nothing buffered, output must hold
    bridge_read(32'h4000_0000 + rd_index * 4, data);
    check_value("save_state_bridge_read_data", data, last_read);
    ss_busy = 1'b0;
    repeat (2) @(negedge clk_74a);
  endtask

  // window writes with random gaps, some foreign writes mixed in
  task automatic host_writes();
    for (int j = 0; j < LOAD_WRITES; j++) begin
      repeat (load_gap[j]) @(negedge clk_74a);
      if (foreign[j]) begin
        bridge_write({4'h2, foreign_data[j][27:0]}, foreign_data[j]);
      end
      bridge_write(32'h4000_0000 + j * 4, load_data[j]);
    end
  endtask

  // requests may run ahead of the host and find the fifo empty
  task automatic manager_loads();
    logic [63:0] expected;
    while (load_pulses == 0) begin
      @(negedge clk_74a);
    end
    ss_busy = 1'b1;
    for (int w = 0; w < LOAD_WRITES / 2; w++) begin
      @(negedge clk_74a);
      ss_req = 1'b1;
      @(negedge clk_74a);
      ss_req = 1'b0;
      wait_for_ack();
      // first write of a pair is the low half
      expected = {byte_swap(load_data[2*w+1]), byte_swap(load_data[2*w])};
      check_value("ss_dout", ss_dout, expected);
    end
    @(negedge clk_74a);
    ss_busy = 1'b0;
  endtask

  task automatic load_session();
    for (int j = 0; j < LOAD_WRITES; j++) begin
      load_data[j]    = $random(seed);
      foreign_data[j] = $random(seed);
      foreign[j]      = ($random(seed) % 3) == 0;
      load_gap[j]     = $unsigned($random(seed)) % 4;
    end
    fork
      host_writes();
      manager_loads();
    join
    check_value("ss_load pulses", load_pulses, 1);
    check_value("ss_save pulses", save_pulses, 1);
  endtask

  task automatic load_completion();
    repeat (2) @(negedge clk_74a);
    savestate_load = 1'b1;
    while (!savestate_load_ack) begin
      @(negedge clk_74a);
    end
    check_value("savestate_load_busy", savestate_load_busy, 0);
    check_value("savestate_load_ok", savestate_load_ok, 0);
    check_value("savestate_start_ok", savestate_start_ok, 0);
    while (!savestate_load_busy) begin
      @(negedge clk_74a);
    end
    check_value("savestate_load_ok", savestate_load_ok, 0);
    // busy lasts one cycle only
    @(negedge clk_74a);
    check_value("savestate_load_busy", savestate_load_busy, 0);
    check_value("savestate_load_ok", savestate_load_ok, 1);
    savestate_load = 1'b0;
    // next save request clears load_ok
    @(negedge clk_74a);
    savestate_start = 1'b1;
    @(negedge clk_74a);
    check_value("ss_save", ss_save, 1);
    check_value("savestate_start_ack", savestate_start_ack, 1);
    check_value("savestate_load_ok", savestate_load_ok, 0);
    savestate_start = 1'b0;
    repeat (3) @(negedge clk_74a);
    check_value("ss_save pulses", save_pulses, 2);
    check_value("ss_load pulses", load_pulses, 1);
  endtask

  initial begin
    seed            = 32'h32d0dc39;
    rst             = 1'b1;
    bridge_wr       = 1'b0;
    bridge_rd       = 1'b0;
    bridge_addr     = '0;
    bridge_wr_data  = '0;
    savestate_load  = 1'b0;
    savestate_start = 1'b0;
    ss_din          = '0;
    ss_req          = 1'b0;
    ss_busy         = 1'b0;
    repeat (3) @(negedge clk_74a);
    rst = 1'b0;
    @(negedge clk_74a);
    check_value("savestate_load_ack", savestate_load_ack, 0);
    check_value("savestate_load_busy", savestate_load_busy, 0);
    check_value("savestate_load_ok", savestate_load_ok, 0);
    check_value("savestate_start_ack", savestate_start_ack, 0);
    check_value("savestate_start_busy", savestate_start_busy, 0);
    check_value("savestate_start_ok", savestate_start_ok, 0);
    check_value("ss_save", ss_save, 0);
    check_value("ss_load", ss_load, 0);
    check_value("ss_ack", ss_ack, 0);
    save_session();
    load_session();
    load_completion();
    $display("SIMULATION PASSED");
    $finish;
  end

  initial begin
    #(WATCHDOG_NS);
    abort_run("watchdog expired before the test sequence finished");
  end

endmodule

//--- hdl/save_state_controller.sv
`timescale 1ns/1ps

module save_state_controller #(
  parameter int LOAD_DEPTH = 2048
) (
  input  logic        clk_74a,
  input  logic        rst,
  input  logic        bridge_wr,
  input  logic        bridge_rd,
  input  logic [31:0] bridge_addr,
  input  logic [31:0] bridge_wr_data,
  output logic [31:0] save_state_bridge_read_data,
  input  logic        savestate_load,
  input  logic        savestate_start,
  output logic        savestate_load_ack,
  output logic        savestate_load_busy,
  output logic        savestate_load_ok,
  output logic        savestate_start_ack,
  output logic        savestate_start_busy,
  output logic        savestate_start_ok,
  output logic        ss_save,
  output logic        ss_load,
  input  logic [63:0] ss_din,
  output logic [63:0] ss_dout,
  input  logic        ss_req,
  input  logic        ss_busy,
  output logic        ss_ack
);
  import save_state_pkg::*;

  logic     load_push;
  logic     load_pop;
  logic     load_clear;
  logic     load_empty;
  logic     save_write;
  logic     save_empty;
  ss_word_u load_word;
  ss_word_u save_word;

  // every write cycle in the window pushes one word
  assign load_push = bridge_wr && (bridge_addr[31:28] == ss_region);

  // bridge writes into 64-bit words for the manager
  load_word_fifo #(
    .LOAD_DEPTH(LOAD_DEPTH)
  ) u_load_fifo (
    .clk_74a       (clk_74a),
    .rst           (rst),
    .load_push     (load_push),
    .load_push_data(bridge_wr_data),
    .load_pop      (load_pop),
    .load_clear    (load_clear),
    .load_word     (load_word),
    .load_empty    (load_empty)
  );

  // manager words out as two bridge reads
  bridge_save_reader u_save_reader (
    .clk_74a                    (clk_74a),
    .rst                        (rst),
    .bridge_rd                  (bridge_rd),
    .bridge_addr                (bridge_addr),
    .save_write                 (save_write),
    .save_word                  (save_word),
    .save_empty                 (save_empty),
    .save_state_bridge_read_data(save_state_bridge_read_data)
  );

  save_state_fsm u_fsm (
    .clk_74a             (clk_74a),
    .rst                 (rst),
    .savestate_start     (savestate_start),
    .savestate_load      (savestate_load),
    .ss_req              (ss_req),
    .ss_busy             (ss_busy),
    .ss_din              (ss_din),
    .load_empty          (load_empty),
    .load_word           (load_word),
    .save_empty          (save_empty),
    .savestate_load_ack  (savestate_load_ack),
    .savestate_load_busy (savestate_load_busy),
    .savestate_load_ok   (savestate_load_ok),
    .savestate_start_ack (savestate_start_ack),
    .savestate_start_busy(savestate_start_busy),
    .savestate_start_ok  (savestate_start_ok),
    .ss_save             (ss_save),
    .ss_load             (ss_load),
    .ss_ack              (ss_ack),
    .ss_dout             (ss_dout),
    .load_pop            (load_pop),
    .load_clear          (load_clear),
    .save_write          (save_write),
    .save_word           (save_word)
  );

endmodule

//--- hdl/save_state_fsm.sv
`timescale 1ns/1ps

module save_state_fsm (
  input  logic                     clk_74a,
  input  logic                     rst,
  input  logic                     savestate_start,
  input  logic                     savestate_load,
  input  logic                     ss_req,
  input  logic                     ss_busy,
  input  logic [63:0]              ss_din,
  input  logic                     load_empty,
  input  save_state_pkg::ss_word_u load_word,
  input  logic                     save_empty,
  output logic                     savestate_load_ack,
  output logic                     savestate_load_busy,
  output logic                     savestate_load_ok,
  output logic                     savestate_start_ack,
  output logic                     savestate_start_busy,
  output logic                     savestate_start_ok,
  output logic                     ss_save,
  output logic                     ss_load,
  output logic                     ss_ack,
  output logic [63:0]              ss_dout,
  output logic                     load_pop,
  output logic                     load_clear,
  output logic                     save_write,
  output save_state_pkg::ss_word_u save_word
);
  import save_state_pkg::*;

  ss_state_e state;

  logic prev_start;
  logic prev_load;
  logic prev_busy;
  logic start_edge;
  logic load_edge;
  logic busy_fall;
  // manager asked while the load fifo was empty
  logic did_req;
  // host load edge seen, waiting for the manager to finish
  logic host_load_req;
  // a load session is underway
  logic loading;
  logic save_take;

  assign start_edge = savestate_start && !prev_start;
  assign load_edge  = savestate_load && !prev_load;
  assign busy_fall  = prev_busy && !ss_busy;

  // manager word accepted in either save request state
  assign save_take = ss_req && (state == save_busy || state == save_wait_req);

  // each half byte-swapped back to manager order
  assign ss_dout = {swap32(load_word.half[1]), swap32(load_word.half[0])};

  // edge detect history
  always_ff @(posedge clk_74a) begin
    if (rst) begin
      prev_start <= 1'b0;
      prev_load  <= 1'b0;
      prev_busy  <= 1'b0;
    end else begin
      prev_start <= savestate_start;
      prev_load  <= savestate_load;
      prev_busy  <= ss_busy;
    end
  end

  // ss_din only valid with ss_req
  always_ff @(posedge clk_74a) begin
    if (save_take) begin
      save_word.raw <= ss_din;
    end
  end

  always_ff @(posedge clk_74a) begin
    if (rst) begin
      state                <= idle;
      did_req              <= 1'b0;
      host_load_req        <= 1'b0;
      loading              <= 1'b0;
      savestate_load_ack   <= 1'b0;
      savestate_load_busy  <= 1'b0;
      savestate_load_ok    <= 1'b0;
      savestate_start_ack  <= 1'b0;
      savestate_start_busy <= 1'b0;
      savestate_start_ok   <= 1'b0;
      ss_save              <= 1'b0;
      ss_load              <= 1'b0;
      ss_ack               <= 1'b0;
      load_pop             <= 1'b0;
      load_clear           <= 1'b0;
      save_write           <= 1'b0;
    end else begin
      // strobes default low
      ss_save    <= 1'b0;
      ss_load    <= 1'b0;
      ss_ack     <= 1'b0;
      load_pop   <= 1'b0;
      load_clear <= 1'b0;
      save_write <= 1'b0;

      // first loaded word kicks off the manager load
      if (!load_empty && !loading && state == idle && !start_edge) begin
        state   <= load_wait_req;
        loading <= 1'b1;
        ss_load <= 1'b1;
      end

      if (start_edge) begin
        // host asks for a save
        state                <= save_busy;
        savestate_start_ack  <= 1'b1;
        savestate_start_ok   <= 1'b0;
        savestate_start_busy <= 1'b0;
        savestate_load_ok    <= 1'b0;
        ss_save              <= 1'b1;
      end else if (load_edge) begin
        // host asks to complete a load already in the manager
        host_load_req      <= 1'b1;
        savestate_load_ack <= 1'b1;
        savestate_load_ok  <= 1'b0;
        savestate_start_ok <= 1'b0;
      end

      case (state)
        save_busy: begin
          savestate_start_ack  <= 1'b0;
          savestate_start_busy <= 1'b1;
          // first word means the save is running
          if (ss_req) begin
            state                <= save_wait_delay;
            save_write           <= 1'b1;
            savestate_start_busy <= 1'b0;
            savestate_start_ok   <= 1'b1;
          end
        end
        save_wait_req: begin
          if (ss_req) begin
            state      <= save_wait_delay;
            save_write <= 1'b1;
          end else if (busy_fall) begin
            state <= idle;
          end
        end
        // let save_empty drop after the write
        save_wait_delay: begin
          state <= save_wait_ack;
        end
        // manager ack waits until the host has read both halves
        save_wait_ack: begin
          if (save_empty) begin
            state  <= save_wait_req;
            ss_ack <= 1'b1;
          end
        end
        load_wait_req: begin
          if (busy_fall) begin
            state <= load_wait_host;
          end else if (!load_empty) begin
            if (did_req || ss_req) begin
              state    <= save_state_pkg::load_pop;
              load_pop <= 1'b1;
              did_req  <= 1'b0;
            end
          end else if (ss_req) begin
            // remember it until data shows up
            did_req <= 1'b1;
          end
        end
        // popped word reaches ss_dout here
        save_state_pkg::load_pop: begin
          state  <= load_wait_req;
          ss_ack <= 1'b1;
        end
        load_wait_host: begin
          if (host_load_req) begin
            state               <= load_complete;
            load_clear          <= 1'b1;
            savestate_load_ack  <= 1'b0;
            savestate_load_busy <= 1'b1;
            host_load_req       <= 1'b0;
          end
        end
        load_complete: begin
          state               <= idle;
          savestate_load_busy <= 1'b0;
          savestate_load_ok   <= 1'b1;
          loading             <= 1'b0;
        end
        default: begin
        end
      endcase
    end
  end

  // load start is held off during a start edge
  no_save_and_load: assert property (
    @(posedge clk_74a) disable iff (rst) !(ss_save && ss_load)
  ) else $error("ss_save and ss_load pulsed together");

  // every ack is a single-cycle pulse
  ack_single_cycle: assert property (
    @(posedge clk_74a) disable iff (rst) ss_ack |=> !ss_ack
  ) else $error("ss_ack held for two cycles");

endmodule

//--- hdl/bridge_save_reader.sv
`timescale 1ns/1ps

module bridge_save_reader (
  input  logic                     clk_74a,
  input  logic                     rst,
  input  logic                     bridge_rd,
  input  logic [31:0]              bridge_addr,
  input  logic                     save_write,
  input  save_state_pkg::ss_word_u save_word,
  output logic                     save_empty,
  output logic [31:0]              save_state_bridge_read_data
);
  import save_state_pkg::*;

  logic        prev_rd;
  logic        rd_edge;
  // word address of the last accepted read
  // top bit is only ever set by reset
  logic [21:0] last_addr;
  logic [21:0] word_addr;
  // which half goes out next
  logic        half_sel;
  logic        pop;
  // one-word save buffer
  ss_word_u    buf_word;

  assign word_addr = {1'b0, bridge_addr[22:2]};

  // rising edge of a read inside the window
  assign rd_edge = bridge_rd && !prev_rd && (bridge_addr[31:28] == ss_region);

  // host retries the same address, so repeats are ignored
  assign pop = rd_edge && !save_empty && (word_addr != last_addr);

  always_ff @(posedge clk_74a) begin
    if (rst) begin
      prev_rd <= 1'b0;
    end else begin
      prev_rd <= bridge_rd;
    end
  end

  // buffer occupancy and half select
  always_ff @(posedge clk_74a) begin
    if (rst) begin
      save_empty <= 1'b1;
      half_sel   <= 1'b0;
      last_addr  <= '1;
    end else if (save_write) begin
      save_empty <= 1'b0;
      half_sel   <= 1'b0;
    end else if (pop) begin
      half_sel  <= ~half_sel;
      last_addr <= word_addr;
      // high half gone, word fully read
      if (half_sel) begin
        save_empty <= 1'b1;
      end
    end
  end

  // low half first, each half byte-swapped for the bridge
  // output holds until the next accepted read
  always_ff @(posedge clk_74a) begin
    if (save_write) begin
      buf_word <= save_word;
    end
    if (pop) begin
      save_state_bridge_read_data <= swap32(buf_word.half[half_sel]);
    end
  end

  // fsm must wait for both halves before handing over the next word
  write_when_empty: assert property (
    @(posedge clk_74a) disable iff (rst) save_write |-> save_empty
  ) else $error("save word written over an unread word");

endmodule

//--- hdl/load_word_fifo.sv
`timescale 1ns/1ps

module load_word_fifo #(
  parameter int LOAD_DEPTH = 2048
) (
  input  logic                     clk_74a,
  input  logic                     rst,
  input  logic                     load_push,
  input  logic [31:0]              load_push_data,
  input  logic                     load_pop,
  input  logic                     load_clear,
  output save_state_pkg::ss_word_u load_word,
  output logic                     load_empty
);
  import save_state_pkg::*;

  localparam int addr_w = $clog2(LOAD_DEPTH);

  // pointers carry one extra wrap bit
  logic [addr_w:0] wr_ptr;
  logic [addr_w:0] rd_ptr;
  // first bridge word of a pair waits here
  logic            half_valid;
  logic [31:0]     half_data;
  logic            load_full;
  logic            pair_done;
  logic            store;
  ss_word_u        push_word;
  logic [63:0]     mem [LOAD_DEPTH];

  assign load_empty = (wr_ptr == rd_ptr);
  // same slot, opposite lap
  assign load_full = (wr_ptr[addr_w] != rd_ptr[addr_w]) &&
                     (wr_ptr[addr_w-1:0] == rd_ptr[addr_w-1:0]);

  // second word of a pair completes a 64-bit entry
  assign pair_done = load_push && half_valid;
  // a pair arriving while full is lost
  assign store = pair_done && !load_full;

  // first write lands in the low half
  always_comb begin
    push_word.half[0] = half_data;
    push_word.half[1] = load_push_data;
  end

  // half-word latch state
  always_ff @(posedge clk_74a) begin
    if (rst || load_clear) begin
      half_valid <= 1'b0;
    end else if (load_push) begin
      half_valid <= ~half_valid;
    end
  end

  always_ff @(posedge clk_74a) begin
    if (load_push && !half_valid) begin
      half_data <= load_push_data;
    end
  end

  // read and write pointers
  always_ff @(posedge clk_74a) begin
    if (rst || load_clear) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
    end else begin
      if (store) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (load_pop && !load_empty) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
    end
  end

  // block ram with registered read
  // popped word shows up the cycle after the pop
  always_ff @(posedge clk_74a) begin
    if (store) begin
      mem[wr_ptr[addr_w-1:0]] <= push_word.raw;
    end
    if (load_pop) begin
      load_word.raw <= mem[rd_ptr[addr_w-1:0]];
    end
  end

  // fsm pops only after it has seen data
  pop_not_empty: assert property (
    @(posedge clk_74a) disable iff (rst) load_pop |-> !load_empty
  ) else $error("load fifo popped while empty");

  // host wrote more than the fifo holds
  push_not_full: assert property (
    @(posedge clk_74a) disable iff (rst || load_clear) pair_done |-> !load_full
  ) else $error("load fifo full, bridge word pair dropped");

endmodule

//--- hdl/save_state_pkg.sv
package save_state_pkg;

  // upper address nibble of the save-state bridge window
  localparam logic [3:0] ss_region = 4'h4;

  // one save-state word, seen two ways
  // raw is the manager view
  // half[0] is the low half and goes first on the bridge
  typedef union packed {
    logic [63:0]      raw;
    logic [1:0][31:0] half;
  } ss_word_u;

  // sequencer states
  // nine states, so four bits
  typedef enum logic [3:0] {
    idle,
    save_busy,
    save_wait_req,
    save_wait_delay,
    save_wait_ack,
    load_wait_req,
    load_pop,
    load_wait_host,
    load_complete
  } ss_state_e;

  // bridge words are big endian, manager words little endian
  function automatic logic [31:0] swap32(input logic [31:0] word);
    return {
      word[7:0],
      word[15:8],
      word[23:16],
      word[31:24]
    };
  endfunction

endpackage
